// ==== list.f ====
verilog/centipede_pkg.sv
verilog/io_decoder.sv
verilog/trakball_axis.sv
verilog/output_latch.sv
verilog/read_mux.sv
verilog/centipede_io.sv
test/centipede_io_asserts.sv
test/tb_centipede_io.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_centipede_io
FILELIST   := list.f
BUILD_DIR  := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert --timescale 1ns/100ps -j 0
LINT_FLAGS := --lint-only -Wall --timing --assert --timescale 1ns/100ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q '\*\* PASS \*\*' $(LOG); then echo "simulation did not complete"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/tb_centipede_io.sv ====
// directed testbench for centipede_io, bus tasks stand in for the 6502
// trackball pins idle low so a flip change never makes a counted edge
module tb_centipede_io import centipede_pkg::*; ();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int CLK_PERIOD   = 8;
   localparam int RESET_CYCLES = 5;
   localparam int NUM_TESTS    = 6;
   // longest test is the trackball one, about 25 pulses of 6 clocks plus reads
   localparam int TEST_CYCLES  = 300;
   localparam int READ_TIMEOUT = 8;

   logic       s_6mhz;
   logic       reset;
   cpu_bus_t   bus;
   logic [9:0] playerinput;
   logic [7:0] trakball;
   logic [7:0] joystick;
   logic [7:0] sw1;
   logic [7:0] sw2;
   logic       vblank;
   logic [7:0] rdata;
   logic       rdata_valid;
   logic [3:0] led;
   logic       flip;

   int seed;
   int errors;
   int checks;
   int tests_run;
   int tests_failed;
   int test_start_errors;

   // expected DUT state
   logic [7:0] exp_latch;
   logic [3:0] exp_cnt_h;
   logic [3:0] exp_cnt_v;
   logic       exp_dir_h;
   logic       exp_dir_v;

   centipede_io dut_i (
      .s_6mhz        (s_6mhz),
      .reset         (reset),
      .bus_i         (bus),
      .playerinput_i (playerinput),
      .trakball_i    (trakball),
      .joystick_i    (joystick),
      .sw1_i         (sw1),
      .sw2_i         (sw2),
      .vblank_i      (vblank),
      .rdata_o       (rdata),
      .rdata_valid_o (rdata_valid),
      .led_o         (led),
      .flip_o        (flip)
   );

   bind centipede_io centipede_io_asserts u_asserts (
      .s_6mhz        (s_6mhz),
      .reset         (reset),
      .bus_i         (bus_i),
      .rdata_o       (rdata_o),
      .rdata_valid_o (rdata_valid_o)
   );

   initial
      s_6mhz = 1'b0;

   always
      #(CLK_PERIOD / 2) s_6mhz = ~s_6mhz;

   task automatic check_value(input string name, input logic [7:0] got,
                              input logic [7:0] expected);
      checks++;
      assert (got === expected)
      else
      begin
         $display("Error: %s got 0x%02h expected 0x%02h", name, got, expected);
         errors++;
      end
   endtask

   task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
      bus.addr  = addr;
      bus.wdata = data;
      bus.wr    = 1'b1;
      @(posedge s_6mhz);
      #1;
      bus.wr = 1'b0;
   endtask

   task automatic bus_read(input logic [15:0] addr, output logic [7:0] data);
      int waited;
      waited   = 0;
      bus.addr = addr;
      bus.rd   = 1'b1;
      @(posedge s_6mhz);
      #1;
      bus.rd = 1'b0;
      while (!rdata_valid && waited < READ_TIMEOUT)
      begin
         @(posedge s_6mhz);
         #1;
         waited++;
      end
      checks++;
      assert (rdata_valid && waited == 0)
      else
      begin
         $display("read of 0x%04h gave no valid data one cycle after the strobe", addr);
         errors++;
      end
      data = rdata;
   endtask

   task automatic check_read(input logic [15:0] addr, input logic [7:0] expected);
      logic [7:0] data;
      bus_read(addr, data);
      check_value($sformatf("rdata_o at 0x%04h", addr), data, expected);
   endtask

   // data bit 7 lands in latch bit addr[2:0]
   task automatic latch_write(input int bit_pos, input logic value);
      bus_write(16'h1C00 | 16'(bit_pos), {value, 7'd0});
      exp_latch[bit_pos] = value;
   endtask

   task automatic compare_latch();
      check_value("flip_o", {7'd0, flip}, {7'd0, exp_latch[LATCH_FLIP]});
      check_value("led_o", {4'd0, led}, {4'd0, exp_latch[LATCH_LED_LO +: 4]});
   endtask

   // dir1, vblank, self test (pin 6), cocktail (pin 5), horizontal count
   function automatic logic [7:0] expect_in0_lo();
      return {exp_dir_h, vblank, playerinput[6], playerinput[5], exp_cnt_h};
   endfunction

   // coins r, c, l then slam, fire2, fire1, start1, start2
   function automatic logic [7:0] expect_in0_hi();
      logic coin_r;
      logic coin_c;
      logic coin_l;
      coin_r = playerinput[9] | exp_latch[LATCH_COIN_R];
      coin_c = playerinput[8] | exp_latch[LATCH_COIN_CL];
      coin_l = playerinput[7] | exp_latch[LATCH_COIN_CL];
      return {coin_r, coin_c, coin_l, playerinput[4], playerinput[1], playerinput[0],
              playerinput[3], playerinput[2]};
   endfunction

   function automatic logic [7:0] expect_in1_lo();
      return {exp_dir_v, 3'b000, exp_cnt_v};
   endfunction

   task automatic randomize_inputs();
      logic [31:0] r;
      r           = $random(seed);
      sw1         = r[7:0];
      sw2         = r[15:8];
      joystick    = r[23:16];
      r           = $random(seed);
      playerinput = r[9:0];
      vblank      = r[10];
   endtask

   // one pulse on an axis clock pin, 3 clocks high then 3 low
   task automatic trak_pulse(input logic vert, input logic player1, input logic dir);
      int ck_bit;
      int dir_bit;
      ck_bit  = (vert ? 0 : 4) + (player1 ? 1 : 0);
      dir_bit = ck_bit + 2;
      trakball[dir_bit] = dir;
      trakball[ck_bit]  = 1'b1;
      repeat (3) @(posedge s_6mhz);
      #1;
      trakball[dir_bit] = 1'b0;
      trakball[ck_bit]  = 1'b0;
      repeat (3) @(posedge s_6mhz);
      #1;
      // only the player picked by flip is counted
      if (player1 == exp_latch[LATCH_FLIP])
      begin
         if (vert)
         begin
            exp_dir_v = dir;
            exp_cnt_v = dir ? exp_cnt_v + 4'd1 : exp_cnt_v - 4'd1;
         end
         else
         begin
            exp_dir_h = dir;
            exp_cnt_h = dir ? exp_cnt_h + 4'd1 : exp_cnt_h - 4'd1;
         end
      end
   endtask

   task automatic report_test(input string name);
      tests_run++;
      if (errors == test_start_errors)
         $display("test %0d %s: ok", tests_run, name);
      else
      begin
         tests_failed++;
         $display("test %0d %s: %0d errors", tests_run, name, errors - test_start_errors);
      end
      test_start_errors = errors;
   endtask

   task automatic reset_defaults();
      compare_latch();
      check_read(16'h0C00, expect_in0_lo());
   endtask

   task automatic read_ports();
      repeat (4)
      begin
         randomize_inputs();
         check_read(16'h0800, sw1);
         check_read(16'h0801, sw2);
         check_read(16'h0C03, joystick);
         check_read(16'h0C00, expect_in0_lo());
         check_read(16'h0C01, expect_in0_hi());
         check_read(16'h0C02, expect_in1_lo());
      end
   endtask

   task automatic latch_outputs();
      playerinput = '0;
      latch_write(LATCH_FLIP, 1'b1);
      compare_latch();
      latch_write(LATCH_LED_LO, 1'b1);
      latch_write(LATCH_LED_LO + 2, 1'b1);
      compare_latch();
      latch_write(LATCH_LED_LO + 3, 1'b1);
      latch_write(LATCH_LED_LO + 1, 1'b1);
      latch_write(LATCH_LED_LO, 1'b0);
      compare_latch();
      // coin drives read back as inserted coins with the pins low
      latch_write(LATCH_COIN_R, 1'b1);
      latch_write(LATCH_COIN_CL, 1'b1);
      check_read(16'h0C01, expect_in0_hi());
      check_value("in0 coin bits", {5'd0, rdata[7:5]}, 8'h07);
      latch_write(LATCH_COIN_R, 1'b0);
      latch_write(LATCH_COIN_CL, 1'b0);
      check_read(16'h0C01, expect_in0_hi());
   endtask

   task automatic trackball_count();
      latch_write(LATCH_FLIP, 1'b1);
      // 17 up steps wrap the horizontal count round to 1
      repeat (17)
         trak_pulse(1'b0, 1'b1, 1'b1);
      repeat (3)
         trak_pulse(1'b1, 1'b1, 1'b0);
      check_read(16'h0C00, expect_in0_lo());
      check_read(16'h0C02, expect_in1_lo());
      repeat (2)
         trak_pulse(1'b0, 1'b1, 1'b0);
      trak_pulse(1'b1, 1'b1, 1'b1);
      check_read(16'h0C00, expect_in0_lo());
      check_read(16'h0C02, expect_in1_lo());
   endtask

   task automatic flip_select();
      latch_write(LATCH_FLIP, 1'b0);
      compare_latch();
      // player 1 pins are ignored now, player 2 pins count
      trak_pulse(1'b0, 1'b1, 1'b1);
      trak_pulse(1'b0, 1'b1, 1'b1);
      trak_pulse(1'b1, 1'b1, 1'b0);
      check_read(16'h0C00, expect_in0_lo());
      check_read(16'h0C02, expect_in1_lo());
      repeat (3)
         trak_pulse(1'b0, 1'b0, 1'b1);
      trak_pulse(1'b1, 1'b0, 1'b0);
      check_read(16'h0C00, expect_in0_lo());
      check_read(16'h0C02, expect_in1_lo());
   endtask

   task automatic steer_clear_unmapped();
      bus_write(16'h2400, 8'h00);
      exp_cnt_h = '0;
      exp_cnt_v = '0;
      check_read(16'h0C00, expect_in0_lo());
      check_read(16'h0C02, expect_in1_lo());
      check_read(16'h0000, 8'h00);
      check_read(16'h0400, 8'h00);
      check_read(16'h1000, 8'h00);
      check_read(16'h1C00, 8'h00);
      check_read(16'h2400, 8'h00);
      check_read(16'h3C00, 8'h00);
   endtask

   // budget covers reset plus every test at its worst case length
   initial
   begin
      #((RESET_CYCLES + NUM_TESTS * TEST_CYCLES) * CLK_PERIOD);
      $display("timeout: tests did not finish within the cycle budget");
      $display("** FAIL **");
      $finish;
   end

   initial
   begin
      seed              = 32'hb955;
      errors            = 0;
      checks            = 0;
      tests_run         = 0;
      tests_failed      = 0;
      test_start_errors = 0;
      exp_latch         = '0;
      exp_cnt_h         = '0;
      exp_cnt_v         = '0;
      exp_dir_h         = 1'b0;
      exp_dir_v         = 1'b0;
      bus               = '0;
      trakball          = '0;
      randomize_inputs();
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge s_6mhz);
      #1;
      reset = 1'b0;

      reset_defaults();
      report_test("reset defaults");
      read_ports();
      report_test("read ports");
      latch_outputs();
      report_test("output latch");
      trackball_count();
      report_test("trackball count");
      flip_select();
      report_test("flip player select");
      steer_clear_unmapped();
      report_test("steering clear and unmapped reads");

      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               tests_run, tests_failed, checks, errors);
      if (errors == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

// ==== test/centipede_io_asserts.sv ====
// read timing rules of the centipede_io bus slave, bound onto the top level
// valid follows a read strobe by one clock and data is zero whenever valid is low
module centipede_io_asserts import centipede_pkg::*;
(
   input logic       s_6mhz,
   input logic       reset,
   input cpu_bus_t   bus_i,
   input logic [7:0] rdata_o,
   input logic       rdata_valid_o
);

   timeunit 1ns;
   timeprecision 100ps;

   // each read strobe gives valid on the next clock
   read_gives_valid: assert property (@(posedge s_6mhz) disable iff (reset)
      bus_i.rd |=> rdata_valid_o)
      else $error("rdata_valid_o missing one cycle after a read strobe");

   // and valid never shows up without one
   valid_needs_read: assert property (@(posedge s_6mhz) disable iff (reset)
      !bus_i.rd |=> !rdata_valid_o)
      else $error("rdata_valid_o high without a read strobe the cycle before");

   // low during reset and on the first clock after it
   valid_low_after_reset: assert property (@(posedge s_6mhz)
      (reset || $fell(reset)) |-> !rdata_valid_o)
      else $error("rdata_valid_o high in or right after reset");

   data_zero_when_idle: assert property (@(posedge s_6mhz)
      !rdata_valid_o |-> (rdata_o == 8'h00))
      else $error("rdata_o nonzero while rdata_valid_o is low");

endmodule

// ==== verilog/centipede_io.sv ====
// centipede processor-side I/O as a single-cycle bus slave on s_6mhz
// at most one strobe per cycle, no wait states
module centipede_io import centipede_pkg::*;
(
   input  logic       s_6mhz,
   input  logic       reset,
   input  cpu_bus_t   bus_i,
   input  logic [9:0] playerinput_i,
   input  logic [7:0] trakball_i,
   input  logic [7:0] joystick_i,
   input  logic [7:0] sw1_i,
   input  logic [7:0] sw2_i,
   input  logic       vblank_i,
   output logic [7:0] rdata_o,
   output logic       rdata_valid_o,
   output logic [3:0] led_o,
   output logic       flip_o
);

   io_sel_t             sel;
   logic                coin_r;
   logic                coin_cl;
   logic [TB_CNT_W-1:0] tra;
   logic [TB_CNT_W-1:0] trb;
   logic                dir1;
   logic                dir2;

   io_decoder u_decoder (
      .bus_i (bus_i),
      .sel_o (sel)
   );

   // trakball_i: 7 p1 h dir, 6 p2 h dir, 5 p1 h ck, 4 p2 h ck, 3..0 same for vertical
   trakball_axis u_horiz (
      .s_6mhz   (s_6mhz),
      .reset    (reset),
      .p1_ck_i  (trakball_i[5]),
      .p1_dir_i (trakball_i[7]),
      .p2_ck_i  (trakball_i[4]),
      .p2_dir_i (trakball_i[6]),
      .flip_i   (flip_o),
      .clear_i  (sel.steerclr),
      .count_o  (tra),
      .dir_o    (dir1)
   );

   trakball_axis u_vert (
      .s_6mhz   (s_6mhz),
      .reset    (reset),
      .p1_ck_i  (trakball_i[1]),
      .p1_dir_i (trakball_i[3]),
      .p2_ck_i  (trakball_i[0]),
      .p2_dir_i (trakball_i[2]),
      .flip_i   (flip_o),
      .clear_i  (sel.steerclr),
      .count_o  (trb),
      .dir_o    (dir2)
   );

   output_latch u_latch (
      .s_6mhz    (s_6mhz),
      .reset     (reset),
      .sel_i     (sel),
      .addr_i    (bus_i.addr[2:0]),
      .data_i    (bus_i.wdata[7]),
      .flip_o    (flip_o),
      .led_o     (led_o),
      .coin_r_o  (coin_r),
      .coin_cl_o (coin_cl)
   );

   read_mux u_read (
      .s_6mhz        (s_6mhz),
      .reset         (reset),
      .sel_i         (sel),
      .playerinput_i (playerinput_i),
      .joystick_i    (joystick_i),
      .sw1_i         (sw1_i),
      .sw2_i         (sw2_i),
      .vblank_i      (vblank_i),
      .tra_i         (tra),
      .dir1_i        (dir1),
      .trb_i         (trb),
      .dir2_i        (dir2),
      .coin_r_i      (coin_r),
      .coin_cl_i     (coin_cl),
      .rdata_o       (rdata_o),
      .rdata_valid_o (rdata_valid_o)
   );

endmodule

// ==== verilog/read_mux.sv ====
// input byte formation and registered read data
// read data appears one clock after the strobe and is zero whenever valid is low
module read_mux import centipede_pkg::*;
(
   input  logic                s_6mhz,
   input  logic                reset,
   input  io_sel_t             sel_i,
   input  logic [9:0]          playerinput_i,
   input  logic [7:0]          joystick_i,
   input  logic [7:0]          sw1_i,
   input  logic [7:0]          sw2_i,
   input  logic                vblank_i,
   input  logic [TB_CNT_W-1:0] tra_i,
   input  logic                dir1_i,
   input  logic [TB_CNT_W-1:0] trb_i,
   input  logic                dir2_i,
   input  logic                coin_r_i,
   input  logic                coin_cl_i,
   output logic [7:0]          rdata_o,
   output logic                rdata_valid_o
);

   logic       coin_r;
   logic       coin_c;
   logic       coin_l;
   logic [7:0] in0_lo;
   logic [7:0] in0_hi;
   logic [7:0] in1_lo;
   logic [7:0] rd_byte;

   // a set counter drive reads as an inserted coin
   assign coin_r = playerinput_i[9] | coin_r_i;
   assign coin_c = playerinput_i[8] | coin_cl_i;
   assign coin_l = playerinput_i[7] | coin_cl_i;

   // dir1, vblank, self test, cocktail, horizontal count
   assign in0_lo = {dir1_i, vblank_i, playerinput_i[6], playerinput_i[5], tra_i};

   // coins, slam, fire2, fire1, start1, start2
   assign in0_hi = {coin_r, coin_c, coin_l, playerinput_i[4],
                    playerinput_i[1], playerinput_i[0],
                    playerinput_i[3], playerinput_i[2]};

   assign in1_lo = {dir2_i, 3'b000, trb_i};

   always_comb
   begin
      rd_byte = 8'h00;
      if (sel_i.in0_rd)
         rd_byte = sel_i.byte_sel ? in0_hi : in0_lo;
      else if (sel_i.in1_rd)
         rd_byte = sel_i.byte_sel ? joystick_i : in1_lo;
      else if (sel_i.sw_rd)
         rd_byte = sel_i.byte_sel ? sw2_i : sw1_i;
   end

   always_ff @(posedge s_6mhz or posedge reset)
   begin
      if (reset)
      begin
         rdata_o       <= 8'h00;
         rdata_valid_o <= 1'b0;
      end
      else
      begin
         rdata_valid_o <= sel_i.rd;
         // unmapped reads fall through as zero
         rdata_o       <= sel_i.rd ? rd_byte : 8'h00;
      end
   end

endmodule

// ==== verilog/output_latch.sv ====
// addressable output latch, data bit 7 goes to latch bit addr[2:0]
// bit 0 has no function on this board
module output_latch import centipede_pkg::*;
(
   input  logic       s_6mhz,
   input  logic       reset,
   input  io_sel_t    sel_i,
   input  logic [2:0] addr_i,
   input  logic       data_i,
   output logic       flip_o,
   output logic [3:0] led_o,
   output logic       coin_r_o,
   output logic       coin_cl_o
);

   logic [7:0] latch_q;

   always_ff @(posedge s_6mhz or posedge reset)
   begin
      if (reset)
         latch_q <= '0;
      else if (sel_i.out0_wr)
         latch_q[addr_i] <= data_i;
   end

   assign flip_o    = latch_q[LATCH_FLIP];
   assign led_o     = latch_q[LATCH_LED_LO +: 4];
   // coin counter drives, also fed back onto the coin inputs
   assign coin_r_o  = latch_q[LATCH_COIN_R];
   assign coin_cl_o = latch_q[LATCH_COIN_CL];

endmodule

// ==== verilog/trakball_axis.sv ====
// one mini-trackball axis, pins are asynchronous and brought into s_6mhz here
// pulses closer than about 4 clocks apart are not all counted
module trakball_axis import centipede_pkg::*;
(
   input  logic                s_6mhz,
   input  logic                reset,
   input  logic                p1_ck_i,
   input  logic                p1_dir_i,
   input  logic                p2_ck_i,
   input  logic                p2_dir_i,
   input  logic                flip_i,
   input  logic                clear_i,
   output logic [TB_CNT_W-1:0] count_o,
   output logic                dir_o
);

   logic                ck_sel;
   logic                dir_sel;
   logic [2:0]          ck_pipe;
   logic [2:0]          dir_pipe;
   logic                edge_q;
   logic [TB_CNT_W-1:0] count_q;
   logic                dir_q;

   // flip high selects player 1, cocktail side otherwise
   assign ck_sel  = flip_i ? p1_ck_i : p2_ck_i;
   assign dir_sel = flip_i ? p1_dir_i : p2_dir_i;

   // two sync stages plus one for edge detect
   // direction runs through the same depth so it stays aligned with its clock edge
   always_ff @(posedge s_6mhz or posedge reset)
   begin
      if (reset)
      begin
         ck_pipe  <= '0;
         dir_pipe <= '0;
         edge_q   <= 1'b0;
      end
      else
      begin
         ck_pipe  <= {ck_pipe[1:0], ck_sel};
         dir_pipe <= {dir_pipe[1:0], dir_sel};
         edge_q   <= ck_pipe[1] & ~ck_pipe[2];
      end
   end

   // direction flop and up/down counter, clear wins over a pulse
   always_ff @(posedge s_6mhz or posedge reset)
   begin
      if (reset)
      begin
         dir_q   <= 1'b0;
         count_q <= '0;
      end
      else if (clear_i)
      begin
         count_q <= '0;
         if (edge_q)
            dir_q <= dir_pipe[2];
      end
      else if (edge_q)
      begin
         dir_q <= dir_pipe[2];
         // step uses the direction being latched this cycle
         if (dir_pipe[2])
            count_q <= count_q + 1'b1;
         else
            count_q <= count_q - 1'b1;
      end
   end

   assign count_o = count_q;
   assign dir_o   = dir_q;

endmodule

// ==== verilog/io_decoder.sv ====
// combinational decode of the I/O page into port selects
// in0 and in1 share one region and are split by address bit 1
module io_decoder import centipede_pkg::*;
(
   input  cpu_bus_t bus_i,
   output io_sel_t  sel_o
);

   logic [3:0] region;
   logic       hit_in;
   logic       hit_sw;
   logic       hit_out0;
   logic       hit_steer;

   assign region = bus_i.addr[13:10];

   always_comb
   begin
      hit_in    = (region == REGION_IN);
      hit_sw    = (region == REGION_SWITCH);
      hit_out0  = (region == REGION_OUT0);
      hit_steer = (region == REGION_STEERCLR);
   end

   always_comb
   begin
      sel_o = '0;

      // read ports
      sel_o.in0_rd = bus_i.rd & hit_in & ~bus_i.addr[1];
      sel_o.in1_rd = bus_i.rd & hit_in & bus_i.addr[1];
      sel_o.sw_rd  = bus_i.rd & hit_sw;
      sel_o.rd     = bus_i.rd;

      // write ports, data is ignored for steering clear
      sel_o.out0_wr  = bus_i.wr & hit_out0;
      sel_o.steerclr = bus_i.wr & hit_steer;

      sel_o.byte_sel = bus_i.addr[0];
   end

endmodule

// ==== verilog/centipede_pkg.sv ====
// address map, latch bit positions and bus types of the centipede I/O page
// decode looks at address bits 13:10 only, so the ports alias across the rest of the map
package centipede_pkg;

   // address bits 13:10 of each I/O region
   localparam logic [3:0] REGION_SWITCH   = 4'd2;
   localparam logic [3:0] REGION_IN       = 4'd3;
   localparam logic [3:0] REGION_OUT0     = 4'd7;
   localparam logic [3:0] REGION_STEERCLR = 4'd9;

   // output latch bit positions
   localparam int LATCH_FLIP    = 7;
   // leds 1 to 4 sit on latch bits 3 to 6
   localparam int LATCH_LED_LO  = 3;
   localparam int LATCH_COIN_R  = 2;
   // one bit drives both centre and left coin counters
   localparam int LATCH_COIN_CL = 1;

   // mini-trackball counter width
   localparam int TB_CNT_W = 4;

   // one processor cycle, strobes last a single clock
   typedef struct packed {
      logic [15:0] addr;
      logic [7:0]  wdata;
      logic        rd;
      logic        wr;
   } cpu_bus_t;

   // decoded port selects, one-hot among the port fields
   typedef struct packed {
      logic in0_rd;
      logic in1_rd;
      logic sw_rd;
      logic out0_wr;
      logic steerclr;
      // any read, mapped or not, so unmapped reads still return valid
      logic rd;
      // address bit 0, picks the byte of a two-byte port
      logic byte_sel;
   } io_sel_t;

endpackage
